//--- all.f
src/disp_pkg.sv
src/colr_pkg.sv
src/display_timing.sv
src/fb_fetch.sv
src/palette_lookup.sv
src/vga_out.sv
src/frame_display_top.sv
testbench/tb_frame_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the frame display testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_frame_display \
    -f all.f -o sim_frame_display > build.log 2>&1 \
    && ./obj_dir/sim_frame_display > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation gave no verdict"; exit 1; }
echo "simulation passed"
exit 0

//--- src/colr_pkg.sv
// colour and memory package
// framebuffer/palette geometry and the host write command word

package colr_pkg;

    localparam int chan_w    = 4;                 // per channel
    localparam int colr_w    = 3 * chan_w;        // r,g,b packed
    localparam int cidx_w    = 4;                 // colour index
    localparam int pal_depth = 16;                // 2**cidx_w entries

    localparam int fb_width  = 160;
    localparam int fb_height = 120;
    localparam int fb_pixels = fb_width * fb_height;   // 19200
    localparam int fb_addr_w = 15;

    // prefetch flag, fb read, palette read
    localparam int fetch_lat = 3;

    // framebuffer view of the payload
    typedef struct packed {
        logic [fb_addr_w-1:0] addr;   // linear pixel address
        logic [cidx_w-1:0]    cidx;
    } fb_wr_t;

    // palette view of the same 19 bits
    typedef struct packed {
        logic [cidx_w-1:0] cidx;      // entry to load
        logic [colr_w-1:0] colr;      // rgb 4:4:4
        logic [2:0]        pad;
    } pal_wr_t;

    typedef union packed {
        fb_wr_t  fb;
        pal_wr_t pal;
    } wr_payload_u;

    typedef enum logic {
        tgt_fb  = 1'b0,
        tgt_pal = 1'b1
    } wr_target_e;

    typedef struct packed {
        logic        valid;           // one cycle per write
        wr_target_e  target;          // picks the payload view
        wr_payload_u payload;
    } host_wr_t;

endpackage

//--- src/disp_pkg.sv
// display timing package
// 640x480 at 60 Hz raster constants and the beam position/sync bundle

package disp_pkg;

    localparam int cord_w = 10;                              // coordinate width

    // horizontal timing in pixels
    localparam logic [cord_w-1:0] h_active     = 10'd640;
    localparam logic [cord_w-1:0] h_sync_start = 10'd656;   // after front porch
    localparam logic [cord_w-1:0] h_sync_end   = 10'd752;   // 96 pixel pulse
    localparam logic [cord_w-1:0] h_total      = 10'd800;

    // vertical timing in lines
    localparam logic [cord_w-1:0] v_active     = 10'd480;
    localparam logic [cord_w-1:0] v_sync_start = 10'd490;
    localparam logic [cord_w-1:0] v_sync_end   = 10'd492;   // two line pulse
    localparam logic [cord_w-1:0] v_total      = 10'd525;

    // beam state, one registered bundle per pixel clock
    typedef struct packed {
        logic [cord_w-1:0] sx;       // column
        logic [cord_w-1:0] sy;       // line
        logic              hsync;    // active low
        logic              vsync;    // active low
        logic              de;       // inside 640x480
        logic              frame;    // pulse at (0,0)
    } disp_t;

endpackage

//--- src/display_timing.sv
// display timing generator
// free running 800x525 raster counters with registered position, syncs, de and frame

`timescale 1ns/1ps

module display_timing (
    input  logic            clk_pix,
    input  logic            rst_n,
    output disp_pkg::disp_t disp
);
    import disp_pkg::*;

    logic [cord_w-1:0] cnt_x;   // next position to present
    logic [cord_w-1:0] cnt_y;
    logic              line_end;
    logic              frame_end;

    assign line_end  = (cnt_x == h_total - 1'b1);
    assign frame_end = (cnt_y == v_total - 1'b1);

    // raster counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cnt_x <= '0;
            cnt_y <= '0;
        end else begin
            if (line_end) begin
                cnt_x <= '0;
                cnt_y <= frame_end ? '0 : cnt_y + 1'b1;   // wrap at v_total
            end else begin
                cnt_x <= cnt_x + 1'b1;
            end
        end
    end

    // everything decoded from the same count so fields line up with sx, sy
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            disp.sx    <= '0;
            disp.sy    <= '0;
            disp.hsync <= 1'b1;   // inactive
            disp.vsync <= 1'b1;
            disp.de    <= 1'b0;
            disp.frame <= 1'b0;
        end else begin
            disp.sx    <= cnt_x;
            disp.sy    <= cnt_y;
            disp.hsync <= ~(cnt_x >= h_sync_start && cnt_x < h_sync_end);
            disp.vsync <= ~(cnt_y >= v_sync_start && cnt_y < v_sync_end);
            disp.de    <= (cnt_x < h_active) && (cnt_y < v_active);
            disp.frame <= (cnt_x == '0) && (cnt_y == '0);
        end
    end

endmodule

//--- src/fb_fetch.sv
// framebuffer fetch
// 160x120 index memory with host write port and a prefetching raster read address

`timescale 1ns/1ps

module fb_fetch (
    input  logic                          clk_pix,
    input  logic                          rst_n,
    input  disp_pkg::disp_t               disp,
    input  colr_pkg::host_wr_t            host_wr,
    output logic [colr_pkg::cidx_w-1:0]   pix_cidx
);
    import disp_pkg::*;
    import colr_pkg::*;

    logic [cidx_w-1:0]    fb_mem [fb_pixels];   // no init, host loads it
    logic                 fb_we;
    logic [fb_addr_w-1:0] rd_addr;              // prefetch pointer
    logic                 fetch_en;             // registered prefetch flag
    logic [cord_w-1:0]    next_sy;              // line after the current one
    logic                 ahead_line;
    logic                 ahead_wrap;
    logic                 frame_fetch;

    // host side, only framebuffer commands and only in range
    assign fb_we = host_wr.valid && (host_wr.target == tgt_fb) &&
                   (host_wr.payload.fb.addr < fb_addr_w'(fb_pixels));

    assign next_sy = (disp.sy == v_total - 1'b1) ? '0 : disp.sy + 1'b1;

    // pixel fetch_lat ahead is painted on this line
    assign ahead_line = (disp.sx < cord_w'(fb_width - fetch_lat)) &&
                        (disp.sy < cord_w'(fb_height));
    // or wraps into the first pixels of the next line
    assign ahead_wrap = (disp.sx >= h_total - cord_w'(fetch_lat)) &&
                        (next_sy < cord_w'(fb_height));

    // one pixel before row 0 prefetch begins
    assign frame_fetch = (disp.sx == h_total - cord_w'(fetch_lat)) &&
                         (disp.sy == v_total - 1'b1);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
            rd_addr  <= '0;
        end else begin
            fetch_en <= ahead_line || ahead_wrap;
            if (frame_fetch) begin
                rd_addr <= '0;                      // new frame, back to pixel 0
            end else if (fetch_en) begin
                rd_addr <= rd_addr + 1'b1;          // one step per painted pixel
            end
        end
    end

    // simple dual port, read returns old data on a same cycle write
    always_ff @(posedge clk_pix) begin
        if (fb_we) begin
            fb_mem[host_wr.payload.fb.addr] <= host_wr.payload.fb.cidx;
        end
        pix_cidx <= fb_mem[rd_addr];
    end

endmodule

//--- src/frame_display_top.sv
// frame display top level
// vga raster plus framebuffer/palette fetch chain, host write port fans out to both memories

`timescale 1ns/1ps

module frame_display_top (
    input  logic                          clk_pix,
    input  logic                          rst_n,
    input  colr_pkg::host_wr_t            host_wr,
    output logic                          vga_hsync,
    output logic                          vga_vsync,
    output logic [colr_pkg::chan_w-1:0]   vga_r,
    output logic [colr_pkg::chan_w-1:0]   vga_g,
    output logic [colr_pkg::chan_w-1:0]   vga_b
);
    import disp_pkg::*;
    import colr_pkg::*;

    disp_t             disp;       // beam position and syncs
    logic [cidx_w-1:0] pix_cidx;   // index out of the framebuffer
    logic [colr_w-1:0] pix_colr;   // colour, aligned with disp

    display_timing display_timing_i (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp)
    );

    fb_fetch fb_fetch_i (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .disp     (disp),
        .host_wr  (host_wr),
        .pix_cidx (pix_cidx)
    );

    palette_lookup palette_lookup_i (
        .clk_pix  (clk_pix),
        .host_wr  (host_wr),
        .pix_cidx (pix_cidx),
        .pix_colr (pix_colr)
    );

    vga_out vga_out_i (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .disp      (disp),
        .pix_colr  (pix_colr),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

//--- src/palette_lookup.sv
// palette lookup
// 16 entry rgb table loaded by the host, registered index to colour read

`timescale 1ns/1ps

module palette_lookup (
    input  logic                          clk_pix,
    input  colr_pkg::host_wr_t            host_wr,
    input  logic [colr_pkg::cidx_w-1:0]   pix_cidx,
    output logic [colr_pkg::colr_w-1:0]   pix_colr
);
    import colr_pkg::*;

    logic [colr_w-1:0] pal_mem [pal_depth];   // undefined until loaded
    logic              pal_we;

    assign pal_we = host_wr.valid && (host_wr.target == tgt_pal);   // palette view only

    always_ff @(posedge clk_pix) begin
        if (pal_we) begin
            pal_mem[host_wr.payload.pal.cidx] <= host_wr.payload.pal.colr;
        end
        pix_colr <= pal_mem[pix_cidx];   // old entry if rewritten this cycle
    end

endmodule

//--- src/vga_out.sv
// vga output stage
// paints the framebuffer area, blanks elsewhere and registers the pins

`timescale 1ns/1ps

module vga_out (
    input  logic                          clk_pix,
    input  logic                          rst_n,
    input  disp_pkg::disp_t               disp,
    input  logic [colr_pkg::colr_w-1:0]   pix_colr,
    output logic                          vga_hsync,
    output logic                          vga_vsync,
    output logic [colr_pkg::chan_w-1:0]   vga_r,
    output logic [colr_pkg::chan_w-1:0]   vga_g,
    output logic [colr_pkg::chan_w-1:0]   vga_b
);
    import disp_pkg::*;
    import colr_pkg::*;

    logic              paint_area;   // top left 160x120
    logic [colr_w-1:0] paint_colr;

    always_comb begin
        paint_area = (disp.sx < cord_w'(fb_width)) && (disp.sy < cord_w'(fb_height));
        // black in blanking and outside the buffer
        paint_colr = (disp.de && paint_area) ? pix_colr : '0;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;                 // syncs idle high
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= disp.hsync;
            vga_vsync <= disp.vsync;
            {vga_r, vga_g, vga_b} <= paint_colr;   // r in the top nibble
        end
    end

endmodule

//--- testbench/tb_frame_display.sv
// frame display testbench
// loads palette and framebuffer over the host port and checks the pins against a raster model

`timescale 1ns/1ps

module tb_frame_display;
    import disp_pkg::*;
    import colr_pkg::*;

    localparam int frame_cycles = 800 * 525;     // one full raster
    localparam logic [1:0] ph_load_pal = 2'd0;
    localparam logic [1:0] ph_load_fb  = 2'd1;
    localparam logic [1:0] ph_rewrite  = 2'd2;   // one palette entry gets a new colour
    localparam logic [1:0] ph_check    = 2'd3;   // count is lines to compare

    // sync pulse extents in pixels and lines, both ends inclusive
    localparam int hs_first = 656;
    localparam int hs_last  = 751;
    localparam int vs_first = 490;
    localparam int vs_last  = 491;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] count;
    } phase_t;

    logic              clk_pix = 1'b0;
    logic              rst_n;
    host_wr_t          host_wr;
    logic              vga_hsync;
    logic              vga_vsync;
    logic [chan_w-1:0] vga_r;
    logic [chan_w-1:0] vga_g;
    logic [chan_w-1:0] vga_b;

    logic [cidx_w-1:0] fb_ref  [fb_pixels];   // mirror of the framebuffer
    logic [colr_w-1:0] pal_ref [pal_depth];   // mirror of the palette
    phase_t            phases  [5];
    logic [31:0]       lfsr;
    int                pin_x;                 // position the pins show now
    int                pin_y;
    logic              colour_on;             // painted area compared once frames are aligned
    int                n_checks;
    int                n_errors;
    int                cycle_cnt = 0;
    int                cycle_limit;

    always #20 clk_pix = ~clk_pix;   // 40 ns period

    frame_display_top frame_display_top_i (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .host_wr   (host_wr),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    // watchdog on total run length
    always @(posedge clk_pix) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles before the phase table finished", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %s got 0x%h expected 0x%h at x %0d y %0d", name, got, exp,
                     pin_x, pin_y);
        end
    endtask

    // reset values on the pins
    task automatic check_idle();
        check_val("vga_hsync", 32'(vga_hsync), 32'd1);
        check_val("vga_vsync", 32'(vga_vsync), 32'd1);
        check_val("vga_r", 32'(vga_r), 32'd0);
        check_val("vga_g", 32'(vga_g), 32'd0);
        check_val("vga_b", 32'(vga_b), 32'd0);
    endtask

    // compare pins with the raster rule and step the model beam
    task automatic check_pixel();
        logic              de;
        logic              in_area;
        logic [colr_w-1:0] exp_colr;
        de       = (pin_x < int'(h_active)) && (pin_y < int'(v_active));
        in_area  = (pin_x < fb_width) && (pin_y < fb_height);
        exp_colr = (de && in_area) ? pal_ref[fb_ref[pin_y * fb_width + pin_x]] : '0;
        check_val("vga_hsync", 32'(vga_hsync), 32'(!(pin_x >= hs_first && pin_x <= hs_last)));
        check_val("vga_vsync", 32'(vga_vsync), 32'(!(pin_y >= vs_first && pin_y <= vs_last)));
        if (colour_on || !in_area) begin
            check_val("vga_r", 32'(vga_r), 32'(exp_colr[11:8]));
            check_val("vga_g", 32'(vga_g), 32'(exp_colr[7:4]));
            check_val("vga_b", 32'(vga_b), 32'(exp_colr[3:0]));
        end
        pin_x++;
        if (pin_x == int'(h_total)) begin
            pin_x = 0;
            pin_y = (pin_y == int'(v_total) - 1) ? 0 : pin_y + 1;
        end
    endtask

    // drive one command on the rising edge and check pins mid cycle
    task automatic tick(input host_wr_t cmd);
        @(posedge clk_pix);
        host_wr <= cmd;
        @(negedge clk_pix);
        check_pixel();
    endtask

    initial begin
        host_wr_t    cmd;
        int          r;
        int          a;
        logic [3:0]  idx;
        logic [11:0] new_colr;

        rst_n       = 1'b0;
        host_wr     = '0;
        lfsr        = 32'hd24b;
        colour_on   = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        pin_x       = 0;
        pin_y       = 0;

        phases[0] = '{kind: ph_load_pal, count: 32'd16};
        phases[1] = '{kind: ph_load_fb,  count: 32'd19200};
        phases[2] = '{kind: ph_check,    count: 32'd480};   // stops at vertical blanking
        phases[3] = '{kind: ph_rewrite,  count: 32'd1};
        phases[4] = '{kind: ph_check,    count: 32'd525};   // whole frame

        // writes plus a frame per check plus a spare frame for the loading raster
        cycle_limit = 0;
        for (r = 0; r < 5; r++) begin
            cycle_limit += (phases[r].kind == ph_check) ? frame_cycles : int'(phases[r].count);
        end
        cycle_limit = (cycle_limit + frame_cycles + 20) * 11 / 10;

        for (r = 0; r < 10; r++) begin
            @(posedge clk_pix);
            @(negedge clk_pix);
            check_idle();
        end
        @(posedge clk_pix);
        rst_n <= 1'b1;
        @(negedge clk_pix);
        check_idle();
        @(posedge clk_pix);      // disp now at (0,0) with pins one behind
        @(negedge clk_pix);
        check_idle();

        for (r = 0; r < 5; r++) begin
            case (phases[r].kind)
                ph_load_pal: begin
                    for (a = 0; a < int'(phases[r].count); a++) begin
                        cmd                  = '0;
                        cmd.valid            = 1'b1;
                        cmd.target           = tgt_pal;
                        cmd.payload.pal.cidx = cidx_w'(a);
                        cmd.payload.pal.colr = colr_w'(take_bits(colr_w));
                        pal_ref[a]           = cmd.payload.pal.colr;
                        tick(cmd);
                    end
                end
                ph_load_fb: begin
                    for (a = 0; a < int'(phases[r].count); a++) begin
                        cmd                 = '0;
                        cmd.valid           = 1'b1;
                        cmd.target          = tgt_fb;
                        cmd.payload.fb.addr = fb_addr_w'(a);
                        cmd.payload.fb.cidx = cidx_w'(take_bits(cidx_w));
                        fb_ref[a]           = cmd.payload.fb.cidx;
                        tick(cmd);
                    end
                end
                ph_rewrite: begin
                    for (a = 0; a < int'(phases[r].count); a++) begin
                        idx      = fb_ref[a];                 // entry used by pixel a
                        new_colr = colr_w'(take_bits(colr_w));
                        if (new_colr == pal_ref[idx]) begin
                            new_colr = ~new_colr;            // must really change
                        end
                        cmd                  = '0;
                        cmd.valid            = 1'b1;
                        cmd.target           = tgt_pal;
                        cmd.payload.pal.cidx = idx;
                        cmd.payload.pal.colr = new_colr;
                        pal_ref[idx]         = new_colr;
                        tick(cmd);
                    end
                end
                default: begin
                    while (!(pin_x == 0 && pin_y == 0)) begin
                        tick('0);                            // wait for the next frame
                    end
                    colour_on = 1'b1;
                    repeat (int'(phases[r].count) * int'(h_total)) tick('0);
                end
            endcase
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
